//--- rtl/ecc_pkg.sv
package ecc_pkg;

    localparam int DATA_W  = 63;
    localparam int PAR_W   = 8;
    localparam int CODE_W  = DATA_W + PAR_W;
    localparam int PADDR_W = 12;
    localparam int PDATA_W = 32;

    localparam logic [PADDR_W-1:0] REG_CTRL     = 12'h000;  // bit 0 bypass
    localparam logic [PADDR_W-1:0] REG_WDATA_LO = 12'h004;
    localparam logic [PADDR_W-1:0] REG_WDATA_HI = 12'h008;  // data 62:32
    localparam logic [PADDR_W-1:0] REG_INJECT   = 12'h00C;
    localparam logic [PADDR_W-1:0] REG_CMD      = 12'h010;
    localparam logic [PADDR_W-1:0] REG_RDATA_LO = 12'h014;
    localparam logic [PADDR_W-1:0] REG_RDATA_HI = 12'h018;
    localparam logic [PADDR_W-1:0] REG_STATUS   = 12'h01C;
    localparam logic [PADDR_W-1:0] REG_ERRCNT   = 12'h020;

    typedef enum logic {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } ecc_op_e;

    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_RD_MEM,
        SEQ_RD_CAP
    } seq_state_e;

    typedef struct packed {
        logic [PAR_W-1:0]  parity;
        logic [DATA_W-1:0] data;
    } codeword_t;

    typedef struct packed {
        logic               psel;
        logic               penable;
        logic               pwrite;
        logic [PADDR_W-1:0] paddr;
        logic [PDATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [PDATA_W-1:0] prdata;
        logic               pready;
        logic               pslverr;
    } apb_rsp_t;

endpackage

//--- rtl/ecc_63_cal.sv
`timescale 1ns/1ps

module ecc_63_cal (
    input  logic [ecc_pkg::DATA_W-1:0] data_in,
    output logic [ecc_pkg::DATA_W-1:0] data_out,
    input  logic [ecc_pkg::PAR_W-1:0]  parity_in,
    output logic [ecc_pkg::PAR_W-1:0]  parity_out,
    input  logic                       bypass,
    output logic                       sbit_err,
    output logic                       dbit_err
);
    import ecc_pkg::*;

    // check matrix, one row of data taps per check bit, row 7 first
    localparam logic [PAR_W-1:0][DATA_W-1:0] H_ROW = {
        63'h172C_D2D3_2DA6_5CB7,
        63'h7E00_0000_0000_0000,
        63'h01FF_FFFF_FC00_0000,
        63'h01FF_FE00_03FF_F800,
        63'h01FE_01FE_03FC_07F0,
        63'h71E1_E1E1_E3C3_C78E,
        63'h4D99_9999_9B33_366D,
        63'h2B55_5555_56AA_AD5B
    };

    logic [PAR_W-1:0]  syndrome;
    logic [DATA_W-1:0] mask;
    logic              data_hit;
    logic              sbit_raw;
    logic              dbit_raw;

    // syndrome produced by a flip of data bit i
    function automatic logic [PAR_W-1:0] column(input int i);
        logic [PAR_W-1:0] c;
        for (int k = 0; k < PAR_W; k++) begin
            c[k] = H_ROW[k][i];
        end
        return c;
    endfunction

    always_comb begin
        for (int k = 0; k < PAR_W; k++) begin
            parity_out[k] = ^(data_in & H_ROW[k]);
        end
    end

    assign syndrome = parity_in ^ parity_out;

    // one-hot correction mask from the syndrome table
    always_comb begin
        for (int i = 0; i < DATA_W; i++) begin
            mask[i] = (syndrome == column(i));
        end
    end

    assign data_hit = |mask;
    assign sbit_raw = data_hit || $onehot(syndrome);  // data or check bit hit
    assign dbit_raw = (syndrome != '0) && !sbit_raw;

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = sbit_raw && !bypass;
    assign dbit_err = dbit_raw && !bypass;

    always_comb begin
        assert final (!(sbit_err && dbit_err))
            else $error("ecc_63_cal: single and double error flagged together");
    end

endmodule

//--- rtl/ecc_store.sv
`timescale 1ns/1ps

module ecc_store #(
    parameter int ADDR_W = 4
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                we,
    input  logic                re,
    input  logic [ADDR_W-1:0]   addr,
    input  ecc_pkg::codeword_t  wcode,
    input  logic [6:0]          flip_a,
    input  logic                flip_a_en,
    input  logic [6:0]          flip_b,
    input  logic                flip_b_en,
    output ecc_pkg::codeword_t  rd_code
);
    import ecc_pkg::*;

    codeword_t         mem [2**ADDR_W];
    logic [CODE_W-1:0] flip_mask;

    // positions above 70 shift out and flip nothing
    always_comb begin
        flip_mask = '0;
        if (flip_a_en) begin
            flip_mask = flip_mask ^ (CODE_W'(1) << flip_a);
        end
        if (flip_b_en) begin
            flip_mask = flip_mask ^ (CODE_W'(1) << flip_b);
        end
    end

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wcode ^ flip_mask;
        end
        if (re) begin
            rd_code <= mem[addr];  // valid next cycle
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) !(we && re))
        else $error("ecc_store: write and read in the same cycle");

endmodule

//--- rtl/ecc_apb_regs.sv
`timescale 1ns/1ps

module ecc_apb_regs #(
    parameter int ADDR_W = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  ecc_pkg::apb_req_t          apb_req,
    output ecc_pkg::apb_rsp_t          apb_rsp,
    output logic [ecc_pkg::DATA_W-1:0] wr_data,
    input  logic [ecc_pkg::PAR_W-1:0]  wr_parity,
    output logic                       bypass,
    output logic                       we,
    output logic                       re,
    output logic [ADDR_W-1:0]          addr,
    output ecc_pkg::codeword_t         wcode,
    output logic [6:0]                 flip_a,
    output logic                       flip_a_en,
    output logic [6:0]                 flip_b,
    output logic                       flip_b_en,
    input  logic [ecc_pkg::DATA_W-1:0] rd_data,
    input  logic                       sbit_err,
    input  logic                       dbit_err
);
    import ecc_pkg::*;

    seq_state_e         state;
    ecc_op_e            cmd_op;
    logic               access;
    logic               cmd_wr;
    logic               rd_cmd;
    logic               ready;
    logic               hit;
    logic               reg_wr;
    logic [31:0]        rd_mux;
    logic [31:0]        wdata_lo;
    logic [DATA_W-33:0] wdata_hi;
    logic [15:0]        inject;
    logic [DATA_W-1:0]  rdata_q;
    logic [1:0]         status;  // {dbit, sbit} of last read
    logic [15:0]        sbit_cnt;
    logic [15:0]        dbit_cnt;

    assign access = apb_req.psel && apb_req.penable;
    assign cmd_op = ecc_op_e'(apb_req.pwdata[31]);
    assign cmd_wr = access && apb_req.pwrite && (apb_req.paddr == REG_CMD);
    assign rd_cmd = cmd_wr && (cmd_op == OP_READ);
    assign ready  = access && (!rd_cmd || state == SEQ_RD_CAP);  // read cmd waits 2
    assign reg_wr = ready && apb_req.pwrite && hit;

    always_comb begin
        hit = 1'b1;
        case (apb_req.paddr)
            REG_CTRL:     rd_mux = {31'd0, bypass};
            REG_WDATA_LO: rd_mux = wdata_lo;
            REG_WDATA_HI: rd_mux = {1'b0, wdata_hi};
            REG_INJECT:   rd_mux = {16'd0, inject};
            REG_CMD:      rd_mux = '0;
            REG_RDATA_LO: rd_mux = rdata_q[31:0];
            REG_RDATA_HI: rd_mux = {1'b0, rdata_q[DATA_W-1:32]};
            REG_STATUS:   rd_mux = {30'd0, status};
            REG_ERRCNT:   rd_mux = {dbit_cnt, sbit_cnt};
            default: begin
                hit    = 1'b0;
                rd_mux = '0;
            end
        endcase
    end

    assign apb_rsp.pready  = ready;
    assign apb_rsp.pslverr = ready && !hit;
    assign apb_rsp.prdata  = (ready && !apb_req.pwrite) ? rd_mux : '0;

    // store request straight from the CMD write
    assign we        = cmd_wr && (cmd_op == OP_WRITE);
    assign re        = rd_cmd && (state == SEQ_IDLE);
    assign addr      = apb_req.pwdata[ADDR_W-1:0];
    assign wr_data   = {wdata_hi, wdata_lo};
    assign wcode     = '{parity: wr_parity, data: wr_data};
    assign flip_a    = inject[6:0];
    assign flip_a_en = inject[7];
    assign flip_b    = inject[14:8];
    assign flip_b_en = inject[15];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bypass   <= 1'b0;
            wdata_lo <= '0;
            wdata_hi <= '0;
            inject   <= '0;
        end else begin
            if (reg_wr) begin
                case (apb_req.paddr)
                    REG_CTRL:     bypass   <= apb_req.pwdata[0];
                    REG_WDATA_LO: wdata_lo <= apb_req.pwdata;
                    REG_WDATA_HI: wdata_hi <= apb_req.pwdata[DATA_W-33:0];
                    REG_INJECT:   inject   <= apb_req.pwdata[15:0];
                    default: ;
                endcase
            end
            if (we) begin
                inject <= '0;  // one-shot
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= SEQ_IDLE;
            rdata_q  <= '0;
            status   <= '0;
            sbit_cnt <= '0;
            dbit_cnt <= '0;
        end else begin
            case (state)
                SEQ_IDLE: begin
                    if (re) begin
                        state <= SEQ_RD_MEM;
                    end
                end
                SEQ_RD_MEM: state <= SEQ_RD_CAP;  // rd_code now valid
                SEQ_RD_CAP: begin
                    state   <= SEQ_IDLE;
                    rdata_q <= rd_data;
                    status  <= {dbit_err, sbit_err};
                    if (sbit_err && sbit_cnt != 16'hFFFF) begin
                        sbit_cnt <= sbit_cnt + 16'd1;
                    end
                    if (dbit_err && dbit_cnt != 16'hFFFF) begin
                        dbit_cnt <= dbit_cnt + 16'd1;
                    end
                end
                default: state <= SEQ_IDLE;
            endcase
            if (reg_wr && apb_req.paddr == REG_ERRCNT) begin
                sbit_cnt <= '0;
                dbit_cnt <= '0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        apb_rsp.pready |-> (apb_req.psel && apb_req.penable))
        else $error("ecc_apb_regs: pready outside an access cycle");

endmodule

//--- rtl/ecc_mem.sv
`timescale 1ns/1ps

module ecc_mem #(
    parameter int ADDR_W = 4
) (
    input  logic              clk,
    input  logic              rst_n,
    input  ecc_pkg::apb_req_t apb_req,
    output ecc_pkg::apb_rsp_t apb_rsp
);
    import ecc_pkg::*;

    logic [DATA_W-1:0] wr_data;
    logic [DATA_W-1:0] rd_data;
    logic [PAR_W-1:0]  wr_parity;
    logic              bypass;
    logic              we;
    logic              re;
    logic [ADDR_W-1:0] addr;
    codeword_t         wcode;
    codeword_t         rd_code;
    logic [6:0]        flip_a;
    logic              flip_a_en;
    logic [6:0]        flip_b;
    logic              flip_b_en;
    logic              sbit_err;
    logic              dbit_err;

    ecc_apb_regs #(
        .ADDR_W(ADDR_W)
    ) u_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .apb_req   (apb_req),
        .apb_rsp   (apb_rsp),
        .wr_data   (wr_data),
        .wr_parity (wr_parity),
        .bypass    (bypass),
        .we        (we),
        .re        (re),
        .addr      (addr),
        .wcode     (wcode),
        .flip_a    (flip_a),
        .flip_a_en (flip_a_en),
        .flip_b    (flip_b),
        .flip_b_en (flip_b_en),
        .rd_data   (rd_data),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

    // encoder only needs the check bits
    ecc_63_cal u_enc (
        .data_in    (wr_data),
        .data_out   (),
        .parity_in  ('0),
        .parity_out (wr_parity),
        .bypass     (1'b0),
        .sbit_err   (),
        .dbit_err   ()
    );

    ecc_store #(
        .ADDR_W(ADDR_W)
    ) u_store (
        .clk       (clk),
        .rst_n     (rst_n),
        .we        (we),
        .re        (re),
        .addr      (addr),
        .wcode     (wcode),
        .flip_a    (flip_a),
        .flip_a_en (flip_a_en),
        .flip_b    (flip_b),
        .flip_b_en (flip_b_en),
        .rd_code   (rd_code)
    );

    ecc_63_cal u_dec (
        .data_in    (rd_code.data),
        .data_out   (rd_data),
        .parity_in  (rd_code.parity),
        .parity_out (),
        .bypass     (bypass),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

endmodule

//--- sim/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int HALF_NS = 2
) (
    output logic clk
);
    initial clk = 1'b0;

    always #(HALF_NS) clk = ~clk;  // 4 ns period

endmodule

//--- sim/ecc_mem_tb.sv
`timescale 1ns/1ps

module ecc_mem_tb;
    import ecc_pkg::*;

    localparam int ADDR_W     = 4;
    localparam int WORDS      = 2**ADDR_W;
    localparam int ACCESSES   = 316;  // summed over all six tests
    localparam int MAX_CYCLES = 4 * ACCESSES * 4;

    logic              clk;
    logic              rst_n;
    apb_req_t          apb_req;
    apb_rsp_t          apb_rsp;
    logic [31:0]       lfsr = 32'hfb90;
    logic [DATA_W-1:0] mem_data [WORDS];
    logic [CODE_W-1:0] mem_flip [WORDS];  // flips stored with each word
    logic [31:0]       wlo_m;
    logic [31:0]       whi_m;
    logic [15:0]       inject_m;
    logic              bypass_m;
    int                sbit_m;
    int                dbit_m;
    int                checks;
    int                errors;
    int                test_errors;
    int                cycles;

    tb_clk_gen clk_gen (.clk(clk));

    ecc_mem #(
        .ADDR_W(ADDR_W)
    ) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v    = {v[62:0], lfsr[0]};
        end
        return v;
    endfunction

    function automatic logic [6:0] rand_pos(input int lo, input int span);
        int v;
        v = int'(rand_bits(7));
        return 7'(lo + v % span);
    endfunction

    function automatic logic [CODE_W-1:0] flips_of(input logic [15:0] inj);
        logic [CODE_W-1:0] m;
        m = '0;
        if (inj[7]) m[inj[6:0]] = 1'b1;
        if (inj[15]) m[inj[14:8]] = 1'b1;
        return m;
    endfunction

    function automatic logic [31:0] cmd_word(input ecc_op_e op, input logic [ADDR_W-1:0] a);
        return {op, {(31-ADDR_W){1'b0}}, a};
    endfunction

    task automatic compare(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t ns: %s is %h, expected %h", $time, what, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic apb_xfer(input logic write, input logic [11:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err, output int waits);
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= a;
        apb_req.pwdata  <= wd;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        waits = 0;
        @(negedge clk);
        while (!apb_rsp.pready) begin  // sampled mid cycle
            waits++;
            @(negedge clk);
        end
        rd  = apb_rsp.prdata;
        err = apb_rsp.pslverr;
        @(posedge clk);
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [11:0] a, input logic [31:0] wd);
        logic [31:0] rd;
        logic        err;
        int          waits;
        apb_xfer(1'b1, a, wd, rd, err, waits);
        compare(64'(err), 64'd0, $sformatf("pslverr on write to %h", a));
    endtask

    task automatic reg_read(input logic [11:0] a, output logic [31:0] rd);
        logic err;
        int   waits;
        apb_xfer(1'b0, a, 32'd0, rd, err, waits);
        compare(64'(err), 64'd0, $sformatf("pslverr on read of %h", a));
    endtask

    task automatic store_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d);
        reg_write(REG_WDATA_LO, d[31:0]);
        reg_write(REG_WDATA_HI, {1'b0, d[DATA_W-1:32]});
        reg_write(REG_CMD, cmd_word(OP_WRITE, a));
        wlo_m       = d[31:0];
        whi_m       = {1'b0, d[DATA_W-1:32]};
        mem_data[a] = d;
        mem_flip[a] = flips_of(inject_m);
        inject_m    = '0;  // one-shot
    endtask

    task automatic write_word(input logic [ADDR_W-1:0] a, input logic [DATA_W-1:0] d,
                              input logic [15:0] inj);
        reg_write(REG_INJECT, {16'd0, inj});
        inject_m = inj;
        store_word(a, d);
    endtask

    task automatic check_word(input logic [ADDR_W-1:0] a, input string tag, output int waits);
        logic [DATA_W-1:0] exp_data;
        logic [1:0]        exp_st;
        logic [31:0]       lo;
        logic [31:0]       hi;
        logic [31:0]       st;
        logic              err;
        int                n;
        exp_data = mem_data[a];
        exp_st   = 2'b00;
        n        = $countones(mem_flip[a]);
        if (bypass_m) begin
            exp_data = exp_data ^ mem_flip[a][DATA_W-1:0];
        end else if (n == 1) begin
            exp_st = 2'b01;
        end else if (n == 2) begin
            exp_st   = 2'b10;
            exp_data = exp_data ^ mem_flip[a][DATA_W-1:0];  // left uncorrected
        end
        sbit_m += int'(exp_st[0]);
        dbit_m += int'(exp_st[1]);
        apb_xfer(1'b1, REG_CMD, cmd_word(OP_READ, a), lo, err, waits);
        compare(64'(err), 64'd0, "pslverr on read command");
        reg_read(REG_RDATA_LO, lo);
        reg_read(REG_RDATA_HI, hi);
        reg_read(REG_STATUS, st);
        compare({hi, lo}, 64'(exp_data), $sformatf("%s data at %0d", tag, a));
        compare(64'(st), 64'(exp_st), $sformatf("%s status at %0d", tag, a));
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) $display("test %s: ok", name);
        else $display("test %s: %0d errors", name, test_errors);
        test_errors = 0;
    endtask

    initial begin
        cycles = 0;
        while (cycles < MAX_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: tests did not finish within %0d cycles", MAX_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        logic [DATA_W-1:0] d;
        logic [ADDR_W-1:0] a;
        logic [6:0]        pa;
        logic [6:0]        pb;
        logic [31:0]       rd;
        logic              err;
        int                waits;
        checks      = 0;
        errors      = 0;
        test_errors = 0;
        sbit_m      = 0;
        dbit_m      = 0;
        bypass_m    = 1'b0;
        inject_m    = '0;
        wlo_m       = '0;
        whi_m       = '0;
        rst_n   <= 1'b0;
        apb_req <= '0;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;

        for (int i = 0; i < WORDS; i++) begin
            write_word(ADDR_W'(i), DATA_W'(rand_bits(DATA_W)), 16'h0000);
        end
        for (int i = 0; i < WORDS; i++) begin
            check_word(ADDR_W'(i), "clean", waits);
            compare(64'(waits), 64'd2, "wait states of a read command");
        end
        end_test("round trip");

        for (int i = 0; i < 8; i++) begin
            a  = ADDR_W'(rand_bits(ADDR_W));
            d  = DATA_W'(rand_bits(DATA_W));
            pa = (i % 2 == 0) ? rand_pos(DATA_W, PAR_W) : rand_pos(0, DATA_W);  // check or data
            write_word(a, d, {8'h00, 1'b1, pa});
            check_word(a, "single", waits);
        end
        end_test("single-bit correction");

        for (int i = 0; i < 8; i++) begin
            a  = ADDR_W'(rand_bits(ADDR_W));
            d  = DATA_W'(rand_bits(DATA_W));
            pa = rand_pos(0, CODE_W);
            pb = pa;
            while (pb == pa) pb = rand_pos(0, CODE_W);
            write_word(a, d, {1'b1, pb, 1'b1, pa});
            check_word(a, "double", waits);
        end
        end_test("double-bit detection");

        reg_write(REG_CTRL, 32'd1);
        bypass_m = 1'b1;
        for (int i = 0; i < 4; i++) begin
            a  = ADDR_W'(rand_bits(ADDR_W));
            d  = DATA_W'(rand_bits(DATA_W));
            pa = rand_pos(0, CODE_W);
            pb = pa;
            while (pb == pa) pb = rand_pos(0, CODE_W);
            write_word(a, d, {i[0], pb, 1'b1, pa});  // odd passes get a second flip
            check_word(a, "bypass", waits);
        end
        reg_write(REG_CTRL, 32'd0);
        bypass_m = 1'b0;
        end_test("bypass");

        reg_read(REG_ERRCNT, rd);
        compare(64'(rd), 64'({16'(dbit_m), 16'(sbit_m)}), "error counts");
        reg_write(REG_ERRCNT, 32'd0);
        sbit_m = 0;
        dbit_m = 0;
        reg_read(REG_ERRCNT, rd);
        compare(64'(rd), 64'd0, "error counts after clear");
        write_word(ADDR_W'(3), DATA_W'(rand_bits(DATA_W)), {8'h00, 1'b1, rand_pos(0, CODE_W)});
        reg_read(REG_INJECT, rd);
        compare(64'(rd), 64'd0, "INJECT after a write command");
        store_word(ADDR_W'(5), DATA_W'(rand_bits(DATA_W)));  // INJECT left alone
        check_word(ADDR_W'(5), "reuse", waits);
        check_word(ADDR_W'(3), "single", waits);
        reg_read(REG_ERRCNT, rd);
        compare(64'(rd), 64'({16'(dbit_m), 16'(sbit_m)}), "error counts after reuse");
        end_test("counters and injection clearing");

        apb_xfer(1'b1, 12'h040, 32'(rand_bits(32)), rd, err, waits);
        compare(64'(err), 64'd1, "pslverr on unmapped write");
        apb_xfer(1'b0, 12'h040, 32'd0, rd, err, waits);
        compare(64'(err), 64'd1, "pslverr on unmapped read");
        compare(64'(rd), 64'd0, "prdata on unmapped read");
        reg_read(REG_CTRL, rd);
        compare(64'(rd), 64'(bypass_m), "CTRL after unmapped access");
        reg_read(REG_WDATA_LO, rd);
        compare(64'(rd), 64'(wlo_m), "WDATA_LO after unmapped access");
        reg_read(REG_WDATA_HI, rd);
        compare(64'(rd), 64'(whi_m), "WDATA_HI after unmapped access");
        reg_read(REG_INJECT, rd);
        compare(64'(rd), 64'(inject_m), "INJECT after unmapped access");
        end_test("error response");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- ecc_mem.f
rtl/ecc_pkg.sv
rtl/ecc_63_cal.sv
rtl/ecc_store.sv
rtl/ecc_apb_regs.sv
rtl/ecc_mem.sv
sim/tb_clk_gen.sv
sim/ecc_mem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ecc_mem_tb -f ecc_mem.f -o Vecc_mem_tb
./obj_dir/Vecc_mem_tb | tee sim.log

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
    echo "simulation ok"
else
    echo "simulation reported a failure"
    exit 1
fi
